//--- Bender.yml
package:
  name: m92_glue

sources:
  - design/m92_pkg.sv
  - design/m92_clock_enables.sv
  - design/m92_sdram_bridge.sv
  - design/m92_io_ports.sv
  - design/m92_pixel_mixer.sv
  - design/m92_audio_mixer.sv
  - design/m92_glue.sv
  - target: test
    files:
      - bench/m92_glue_sdram_model.sv
      - bench/m92_glue_tb.sv

//--- m92_glue.f
design/m92_pkg.sv
design/m92_clock_enables.sv
design/m92_sdram_bridge.sv
design/m92_io_ports.sv
design/m92_pixel_mixer.sv
design/m92_audio_mixer.sv
design/m92_glue.sv
bench/m92_glue_sdram_model.sv
bench/m92_glue_tb.sv

//--- bench/m92_glue_tb.sv
// Testbench for the M92 glue logic
// I/O, flag register, pixel, memory and audio traffic with checks on every response

`timescale 1ns/1ps
`default_nettype none

module m92_glue_tb
    import m92_pkg::*;
();

    localparam int         CLK_PERIOD      = 40;
    localparam int         RESET_CYCLES    = 16;
    localparam int         WATCHDOG_CYCLES = 4000;   // Several times the test length
    localparam logic [3:0] RAM_BANK        = 4'hE;

    logic       CLK_32M, reset_n;
    logic       mem_read, mem_write, mem_busy;
    cpu_addr_t  mem_addr;
    word_t      mem_wdata, mem_rdata;
    logic [1:0] mem_sel;
    logic       io_write;
    logic [7:0] io_addr, io_wdata, io_rdata;
    logic [1:0] coin, start_buttons;
    logic [3:0] p1_joystick, p2_joystick, p1_buttons, p2_buttons;
    logic       service_button, tnsl;
    word_t      dip_sw;
    logic       ce_pix, p1l, en_sprites, en_sprite_palette;
    logic [7:0] obj_pix, red, green, blue;
    colour5_t   char_r, char_g, char_b, obj_pal_r, obj_pal_g, obj_pal_b;
    word_t      ym_audio, audio_l, audio_r;
    logic [7:0] sample;
    sdr_addr_t  sdr_addr;
    word_t      sdr_wdata, sdr_rdata;
    logic [1:0] sdr_wr_sel, coin_counter;
    logic       sdr_req, sdr_rdy;
    logic       ce_cpu, ce_cpu_4x, ce_mcu, sound_busreq, flip;

    int         seed = 32'h7cab;
    int         req_count;
    sdr_addr_t  exp_sdr_addr;
    word_t      exp_sdr_wdata;
    logic [1:0] exp_wr_sel;
    logic       exp_write;
    word_t      ref_mem [0:7];
    int         n_4x, edges;
    logic       exp_4x;
    logic       exp_cpu;
    logic [3:0] mcu_hist;
    int         mcu_ones;

    m92_glue #(
        .cpu_ce_div   (4),
        .mcu_ce_div   (4),
        .sdr_cpu_base ('0),
        .ram_bank     (RAM_BANK)
    ) u_dut (.*);

    m92_glue_sdram_model u_sdram (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .sdr_addr   (sdr_addr),
        .sdr_wdata  (sdr_wdata),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_rdata  (sdr_rdata),
        .sdr_rdy    (sdr_rdy)
    );

    initial begin
        CLK_32M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_32M = ~CLK_32M;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK_32M);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    task automatic report_failure(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // ========================================
    // Enable and request monitor
    // ========================================

    always @(posedge CLK_32M) begin
        if (!reset_n) begin
            exp_4x    = 1'b0;
            n_4x      = 0;
            edges     = 0;
            mcu_hist  = '0;
            req_count = 0;
        end else begin
            edges++;
            assert (ce_cpu_4x == exp_4x)   // Stall shows one cycle after busy
                else report_failure("ce_cpu_4x stall", exp_4x, ce_cpu_4x);
            if (exp_4x)
                n_4x++;
            exp_cpu = exp_4x && (n_4x % 4 == 0);
            assert (ce_cpu == exp_cpu)
                else report_failure("ce_cpu every fourth ce_cpu_4x", exp_cpu, ce_cpu);
            exp_4x = !mem_busy;

            // First cycle after reset still shows the reset value
            if (edges >= 2)
                mcu_hist = {mcu_hist[2:0], ce_mcu};
            mcu_ones = mcu_hist[0] + mcu_hist[1] + mcu_hist[2] + mcu_hist[3];
            if (edges >= 5)
                assert (mcu_ones == 1)
                    else report_failure("ce_mcu pulses per window of four", 1, mcu_ones);

            if (sdr_req) begin
                req_count++;
                assert (sdr_addr == exp_sdr_addr)
                    else report_failure("sdr_addr", exp_sdr_addr, sdr_addr);
                assert (sdr_wr_sel == exp_wr_sel)
                    else report_failure("sdr_wr_sel", exp_wr_sel, sdr_wr_sel);
                if (exp_write)
                    assert (sdr_wdata == exp_sdr_wdata)
                        else report_failure("sdr_wdata", exp_sdr_wdata, sdr_wdata);
            end
        end
    end

    // ========================================
    // Stimulus tasks, all called on a falling edge
    // ========================================

    function automatic logic [7:0] io_expect(input logic [7:0] addr);
        word_t w;
        case ({addr[7:1], 1'b0})
            8'h00:   w = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
            8'h02:   w = {8'hFF, tnsl, 2'b11, ~service_button, coin, start_buttons};
            8'h04:   w = dip_sw;
            default: w = 16'hFFFF;
        endcase
        return addr[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic check_io_read(input logic [7:0] addr);
        io_addr = addr;
        @(negedge CLK_32M);
        assert (io_rdata == io_expect(addr))
            else report_failure("io readback", io_expect(addr), io_rdata);
    endtask

    task automatic write_flags(input logic [7:0] value);
        logic exp_flip;
        io_addr  = IO_ADDR_FLAGS;
        io_wdata = value;
        io_write = 1'b1;
        @(negedge CLK_32M);
        io_write = 1'b0;
        exp_flip = ~value[FLAG_SOFT_NL] ^ dip_sw[DIP_FLIP_BIT];
        assert (coin_counter == value[1:0])
            else report_failure("coin_counter", value[1:0], coin_counter);
        assert (sound_busreq == ~value[FLAG_BRQ])
            else report_failure("sound_busreq", ~value[FLAG_BRQ], sound_busreq);
        assert (flip == exp_flip)
            else report_failure("flip", exp_flip, flip);
    endtask

    function automatic logic [7:0] expand5(input colour5_t c);
        return {c, c[4:2]};
    endfunction

    task automatic pixel_check(input logic blank);
        colour5_t   pr, pg, pb;
        logic [7:0] er, eg, eb;
        obj_pix   = 8'($random(seed));
        p1l       = 1'($random(seed));
        char_r    = 5'($random(seed));
        char_g    = 5'($random(seed));
        char_b    = 5'($random(seed));
        obj_pal_r = 5'($random(seed));
        obj_pal_g = 5'($random(seed));
        obj_pal_b = 5'($random(seed));
        ce_pix    = 1'b1;
        @(negedge CLK_32M);
        ce_pix = 1'b0;
        if (!(en_sprites && obj_pix[3:0] != 4'h0 && p1l)) begin
            {pr, pg, pb} = {char_r, char_g, char_b};
        end else if (en_sprite_palette) begin
            {pr, pg, pb} = {obj_pal_r, obj_pal_g, obj_pal_b};
        end else begin
            pr = {obj_pix[3:0], 1'b0};
            pg = pr;
            pb = pr;
        end
        er = blank ? 8'h00 : expand5(pr);
        eg = blank ? 8'h00 : expand5(pg);
        eb = blank ? 8'h00 : expand5(pb);
        assert (red == er)   else report_failure("pixel red", er, red);
        assert (green == eg) else report_failure("pixel green", eg, green);
        assert (blue == eb)  else report_failure("pixel blue", eb, blue);
    endtask

    task automatic mem_access(input logic wr, input cpu_addr_t addr, input word_t wdata,
                              input logic [1:0] sel, output word_t rdata);
        int req_before;
        exp_sdr_addr  = sdr_addr_t'({addr[19:1], 1'b0});
        exp_write     = wr;
        exp_sdr_wdata = addr[0] ? {wdata[7:0], 8'h00} : wdata;
        if (!wr || addr[19:16] != RAM_BANK)
            exp_wr_sel = 2'b00;
        else
            exp_wr_sel = addr[0] ? {sel[0], 1'b0} : sel;
        req_before = req_count;
        mem_addr   = addr;
        mem_wdata  = wdata;
        mem_sel    = sel;
        mem_read   = !wr;
        mem_write  = wr;
        do @(negedge CLK_32M); while (!mem_busy);
        while (mem_busy)
            @(negedge CLK_32M);
        rdata     = mem_rdata;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        @(negedge CLK_32M);   // Strobes low for an edge before the next access
        assert (req_count - req_before == 1)
            else report_failure("one sdr_req per access", 1, req_count - req_before);
    endtask

    task automatic ref_write(input cpu_addr_t addr, input word_t wdata, input logic [1:0] sel);
        if (addr[19:16] == RAM_BANK) begin
            if (addr[0]) begin
                if (sel[0])
                    ref_mem[addr[3:1]][15:8] = wdata[7:0];
            end else begin
                if (sel[0])
                    ref_mem[addr[3:1]][7:0] = wdata[7:0];
                if (sel[1])
                    ref_mem[addr[3:1]][15:8] = wdata[15:8];
            end
        end
    endtask

    function automatic word_t ref_read(input cpu_addr_t addr);
        word_t w;
        w = ref_mem[addr[3:1]];
        return addr[0] ? {8'h00, w[15:8]} : w;
    endfunction

    task automatic audio_check(input word_t ym, input logic [7:0] smp);
        int    sum;
        word_t expected;
        ym_audio = ym;
        sample   = smp;
        @(negedge CLK_32M);
        sum      = $signed(ym) + (int'(smp) - 128) * 256;
        expected = sum[16:1];
        assert (audio_l == expected) else report_failure("audio_l", expected, audio_l);
        assert (audio_r == expected) else report_failure("audio_r", expected, audio_r);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin : stimulus
        word_t      rdata;
        cpu_addr_t  addr;
        word_t      wdata;
        logic [1:0] sel;
        logic [7:0] flags_byte;

        reset_n           = 1'b0;
        {mem_read, mem_write, io_write, ce_pix} = '0;
        mem_addr          = '0;
        mem_wdata         = '0;
        mem_sel           = 2'b00;
        {io_addr, io_wdata} = '0;
        {coin, start_buttons} = '0;
        {p1_joystick, p2_joystick, p1_buttons, p2_buttons} = '0;
        {service_button, tnsl, p1l} = '0;
        dip_sw            = '0;
        en_sprites        = 1'b1;
        en_sprite_palette = 1'b1;
        obj_pix           = '0;
        {char_r, char_g, char_b, obj_pal_r, obj_pal_g, obj_pal_b} = '0;
        ym_audio          = '0;
        sample            = SAMPLE_BIAS;
        repeat (RESET_CYCLES) @(negedge CLK_32M);
        reset_n = 1'b1;

        for (int round = 0; round < 3; round++) begin
            {p2_buttons, p2_joystick, p1_buttons, p1_joystick} = 16'($random(seed));
            {coin, start_buttons, service_button, tnsl} = 6'($random(seed));
            dip_sw = 16'($random(seed));
            for (int a = 0; a < 6; a++)
                check_io_read(8'(a));
            check_io_read(8'h37);   // Unmapped
        end

        for (int i = 0; i < 16; i++) begin
            dip_sw     = 16'($random(seed));
            flags_byte = 8'($random(seed));
            write_flags(flags_byte);
            pixel_check(flags_byte[FLAG_CBLK]);
        end

        write_flags(8'h00);
        for (int mode = 0; mode < 4; mode++) begin
            en_sprites        = mode[0];
            en_sprite_palette = mode[1];
            repeat (10) pixel_check(1'b0);
        end

        for (int i = 0; i < 8; i++) begin
            addr  = {RAM_BANK, 12'h000, 3'(i), 1'b0};
            wdata = 16'($random(seed));
            mem_access(1'b1, addr, wdata, 2'b11, rdata);
            ref_write(addr, wdata, 2'b11);
        end
        repeat (12) begin
            addr  = {RAM_BANK, 12'h000, 4'($random(seed))};
            wdata = 16'($random(seed));
            sel   = 2'($random(seed));
            mem_access(1'b1, addr, wdata, sel, rdata);
            ref_write(addr, wdata, sel);
            mem_access(1'b0, addr, 16'h0000, 2'b11, rdata);
            assert (rdata == ref_read(addr))
                else report_failure("memory readback", ref_read(addr), rdata);
        end
        // ROM bank aliases word 3 of the SDRAM model
        addr = 20'h0_0006;
        mem_access(1'b1, addr, 16'hDEAD, 2'b11, rdata);
        ref_write(addr, 16'hDEAD, 2'b11);
        for (int i = 0; i < 16; i++) begin
            addr = {RAM_BANK, 12'h000, 4'(i)};
            mem_access(1'b0, addr, 16'h0000, 2'b11, rdata);
            assert (rdata == ref_read(addr))
                else report_failure("memory sweep", ref_read(addr), rdata);
        end

        repeat (20) audio_check(16'($random(seed)), 8'($random(seed)));
        audio_check(16'h7FFF, 8'hFF);
        audio_check(16'h8000, 8'h00);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/m92_glue_sdram_model.sv
// SDRAM responder for the glue testbench
// 64-word memory, byte-select writes, ready after a random 1 to 6 cycles

`timescale 1ns/1ps
`default_nettype none

module m92_glue_sdram_model
    import m92_pkg::*;
(
    input  wire        CLK_32M,
    input  wire        reset_n,
    input  sdr_addr_t  sdr_addr,
    input  word_t      sdr_wdata,
    input  wire  [1:0] sdr_wr_sel,
    input  wire        sdr_req,
    output word_t      sdr_rdata,
    output logic       sdr_rdy
);

    int         seed = 32'h7cab;
    word_t      mem [0:63];
    logic [5:0] idx;
    logic [2:0] wait_cnt;
    logic       pending;

    initial begin
        for (int i = 0; i < 64; i++)
            mem[i] = {2'b10, 6'(i), ~6'(i), 2'b01};   // Pattern over the whole word address
    end

    always @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sdr_rdy   <= 1'b0;
            sdr_rdata <= '0;
            idx       <= '0;
            wait_cnt  <= '0;
            pending   <= 1'b0;
        end else begin
            sdr_rdy <= 1'b0;
            if (sdr_req) begin
                idx      <= sdr_addr[6:1];
                wait_cnt <= 3'(1 + {$random(seed)} % 6);
                pending  <= 1'b1;
                if (sdr_wr_sel[0])
                    mem[sdr_addr[6:1]][7:0] <= sdr_wdata[7:0];
                if (sdr_wr_sel[1])
                    mem[sdr_addr[6:1]][15:8] <= sdr_wdata[15:8];
            end else if (pending) begin
                if (wait_cnt == 3'd1) begin
                    sdr_rdy   <= 1'b1;
                    sdr_rdata <= mem[idx];
                    pending   <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/m92_glue.sv
// M92 main board glue logic
// Clock enables, SDRAM bridge, I/O ports, pixel and audio mixing

`timescale 1ns/1ps
`default_nettype none

module m92_glue
    import m92_pkg::*;
#(
    parameter int         cpu_ce_div   = 4,
    parameter int         mcu_ce_div   = 4,
    parameter sdr_addr_t  sdr_cpu_base = '0,
    parameter logic [3:0] ram_bank     = 4'hE
) (
    input  wire        CLK_32M,
    input  wire        reset_n,
    // CPU memory bus
    input  wire        mem_read,
    input  wire        mem_write,
    input  cpu_addr_t  mem_addr,
    input  word_t      mem_wdata,
    input  wire  [1:0] mem_sel,
    output word_t      mem_rdata,
    output logic       mem_busy,
    // CPU I/O bus
    input  wire        io_write,
    input  wire  [7:0] io_addr,
    input  wire  [7:0] io_wdata,
    output logic [7:0] io_rdata,
    // Player inputs
    input  wire  [1:0] coin,
    input  wire  [1:0] start_buttons,
    input  wire  [3:0] p1_joystick,
    input  wire  [3:0] p2_joystick,
    input  wire  [3:0] p1_buttons,
    input  wire  [3:0] p2_buttons,
    input  wire        service_button,
    input  wire        tnsl,
    input  word_t      dip_sw,
    // Video
    input  wire        ce_pix,
    input  wire        p1l,
    input  wire        en_sprites,
    input  wire        en_sprite_palette,
    input  wire  [7:0] obj_pix,
    input  colour5_t   char_r,
    input  colour5_t   char_g,
    input  colour5_t   char_b,
    input  colour5_t   obj_pal_r,
    input  colour5_t   obj_pal_g,
    input  colour5_t   obj_pal_b,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    // Audio
    input  word_t      ym_audio,
    input  wire  [7:0] sample,
    output word_t      audio_l,
    output word_t      audio_r,
    // SDRAM CPU port
    output sdr_addr_t  sdr_addr,
    output word_t      sdr_wdata,
    output logic [1:0] sdr_wr_sel,
    output logic       sdr_req,
    input  word_t      sdr_rdata,
    input  wire        sdr_rdy,
    // Enables and board controls
    output logic       ce_cpu,
    output logic       ce_cpu_4x,
    output logic       ce_mcu,
    output logic [1:0] coin_counter,
    output logic       sound_busreq,
    output logic       flip
);

    logic cblk;   // Screen blank from flag register

    m92_clock_enables #(
        .cpu_ce_div (cpu_ce_div),
        .mcu_ce_div (mcu_ce_div)
    ) u_clock_enables (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .mem_busy  (mem_busy),
        .ce_cpu    (ce_cpu),
        .ce_cpu_4x (ce_cpu_4x),
        .ce_mcu    (ce_mcu)
    );

    m92_sdram_bridge #(
        .sdr_cpu_base (sdr_cpu_base),
        .ram_bank     (ram_bank)
    ) u_sdram_bridge (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_sel    (mem_sel),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy),
        .sdr_addr   (sdr_addr),
        .sdr_wdata  (sdr_wdata),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_rdata  (sdr_rdata),
        .sdr_rdy    (sdr_rdy)
    );

    m92_io_ports u_io_ports (
        .CLK_32M        (CLK_32M),
        .reset_n        (reset_n),
        .io_write       (io_write),
        .io_addr        (io_addr),
        .io_wdata       (io_wdata),
        .io_rdata       (io_rdata),
        .coin           (coin),
        .start_buttons  (start_buttons),
        .p1_joystick    (p1_joystick),
        .p2_joystick    (p2_joystick),
        .p1_buttons     (p1_buttons),
        .p2_buttons     (p2_buttons),
        .service_button (service_button),
        .tnsl           (tnsl),
        .dip_sw         (dip_sw),
        .coin_counter   (coin_counter),
        .cblk           (cblk),
        .sound_busreq   (sound_busreq),
        .flip           (flip)
    );

    m92_pixel_mixer u_pixel_mixer (
        .CLK_32M           (CLK_32M),
        .reset_n           (reset_n),
        .ce_pix            (ce_pix),
        .cblk              (cblk),
        .p1l               (p1l),
        .en_sprites        (en_sprites),
        .en_sprite_palette (en_sprite_palette),
        .obj_pix           (obj_pix),
        .char_r            (char_r),
        .char_g            (char_g),
        .char_b            (char_b),
        .obj_pal_r         (obj_pal_r),
        .obj_pal_g         (obj_pal_g),
        .obj_pal_b         (obj_pal_b),
        .red               (red),
        .green             (green),
        .blue              (blue)
    );

    m92_audio_mixer u_audio_mixer (
        .CLK_32M  (CLK_32M),
        .reset_n  (reset_n),
        .ym_audio (ym_audio),
        .sample   (sample),
        .audio_l  (audio_l),
        .audio_r  (audio_r)
    );

endmodule

`default_nettype wire

//--- design/m92_audio_mixer.sv
// Audio mixer
// FM plus signed sample, one bit of headroom, same mix on both channels

`timescale 1ns/1ps
`default_nettype none

module m92_audio_mixer
    import m92_pkg::*;
(
    input  wire        CLK_32M,
    input  wire        reset_n,
    input  word_t      ym_audio,
    input  wire  [7:0] sample,
    output word_t      audio_l,
    output word_t      audio_r
);

    logic [7:0]  sample_s;
    logic [16:0] mix;

    assign sample_s = sample - SAMPLE_BIAS;   // Unsigned to signed

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n)
            mix <= '0;
        else
            mix <= {ym_audio[15], ym_audio} + {sample_s[7], sample_s, 8'h00};
    end

    assign audio_l = mix[16:1];
    assign audio_r = mix[16:1];

endmodule

`default_nettype wire

//--- design/m92_pixel_mixer.sv
// Final pixel mixer
// Sprite over background priority, 5 to 8 bit expansion and blanking

`timescale 1ns/1ps
`default_nettype none

module m92_pixel_mixer
    import m92_pkg::*;
(
    input  wire        CLK_32M,
    input  wire        reset_n,
    input  wire        ce_pix,
    input  wire        cblk,
    input  wire        p1l,
    input  wire        en_sprites,
    input  wire        en_sprite_palette,
    input  wire  [7:0] obj_pix,
    input  colour5_t   char_r,
    input  colour5_t   char_g,
    input  colour5_t   char_b,
    input  colour5_t   obj_pal_r,
    input  colour5_t   obj_pal_g,
    input  colour5_t   obj_pal_b,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    colour5_t obj_r, obj_g, obj_b;
    colour5_t mix_r, mix_g, mix_b;
    logic     obj_vis;
    logic     obj_sel;

    // Raw sprite index as grey when the palette is off
    assign obj_r = en_sprite_palette ? obj_pal_r : {obj_pix[3:0], 1'b0};
    assign obj_g = en_sprite_palette ? obj_pal_g : {obj_pix[3:0], 1'b0};
    assign obj_b = en_sprite_palette ? obj_pal_b : {obj_pix[3:0], 1'b0};

    assign obj_vis = en_sprites && (obj_pix[3:0] != 4'h0);
    assign obj_sel = obj_vis && p1l;

    assign mix_r = obj_sel ? obj_r : char_r;
    assign mix_g = obj_sel ? obj_g : char_g;
    assign mix_b = obj_sel ? obj_b : char_b;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            red   <= 8'h00;
            green <= 8'h00;
            blue  <= 8'h00;
        end else if (ce_pix) begin
            red   <= cblk ? 8'h00 : {mix_r, mix_r[4:2]};
            green <= cblk ? 8'h00 : {mix_g, mix_g[4:2]};
            blue  <= cblk ? 8'h00 : {mix_b, mix_b[4:2]};
        end
    end

endmodule

`default_nettype wire

//--- design/m92_io_ports.sv
// System I/O ports
// Flag register at 0x02 and byte readback of switches, flags and DIPs

`timescale 1ns/1ps
`default_nettype none

module m92_io_ports
    import m92_pkg::*;
(
    input  wire        CLK_32M,
    input  wire        reset_n,
    input  wire        io_write,
    input  wire  [7:0] io_addr,
    input  wire  [7:0] io_wdata,
    output logic [7:0] io_rdata,
    input  wire  [1:0] coin,
    input  wire  [1:0] start_buttons,
    input  wire  [3:0] p1_joystick,
    input  wire  [3:0] p2_joystick,
    input  wire  [3:0] p1_buttons,
    input  wire  [3:0] p2_buttons,
    input  wire        service_button,
    input  wire        tnsl,
    input  word_t      dip_sw,
    output logic [1:0] coin_counter,
    output logic       cblk,
    output logic       sound_busreq,
    output logic       flip
);

    logic [7:0] sys_flags;
    word_t      switches;
    word_t      flags;
    word_t      io16;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n)
            sys_flags <= 8'h00;
        else if (io_write && io_addr == IO_ADDR_FLAGS)
            sys_flags <= io_wdata;
    end

    // Board controls decoded from the flag register
    assign coin_counter = {sys_flags[FLAG_COIN1], sys_flags[FLAG_COIN0]};
    assign cblk         = sys_flags[FLAG_CBLK];
    assign sound_busreq = ~sys_flags[FLAG_BRQ];
    assign flip         = ~sys_flags[FLAG_SOFT_NL] ^ dip_sw[DIP_FLIP_BIT];

    // ========================================
    // Readback
    // ========================================

    assign switches = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
    assign flags    = {8'hFF, tnsl, 2'b11,
                       ~service_button,   // Service, active low
                       coin, start_buttons};

    always_comb begin
        case ({io_addr[7:1], 1'b0})
            IO_ADDR_SWITCHES: io16 = switches;
            IO_ADDR_FLAGS:    io16 = flags;
            IO_ADDR_DIPS:     io16 = dip_sw;
            default:          io16 = 16'hFFFF;
        endcase
        io_rdata = io_addr[0] ? io16[15:8] : io16[7:0];
    end

endmodule

`default_nettype wire

//--- design/m92_sdram_bridge.sv
// CPU memory bus to SDRAM bridge
// One request pulse per access, odd byte addresses moved to the right lane,
// writes outside the work RAM bank go out with no byte selects

`timescale 1ns/1ps
`default_nettype none

module m92_sdram_bridge
    import m92_pkg::*;
#(
    parameter sdr_addr_t  sdr_cpu_base = '0,
    parameter logic [3:0] ram_bank     = 4'hE
) (
    input  wire        CLK_32M,
    input  wire        reset_n,
    input  wire        mem_read,
    input  wire        mem_write,
    input  cpu_addr_t  mem_addr,
    input  word_t      mem_wdata,
    input  wire  [1:0] mem_sel,
    output word_t      mem_rdata,
    output logic       mem_busy,
    output sdr_addr_t  sdr_addr,
    output word_t      sdr_wdata,
    output logic [1:0] sdr_wr_sel,
    output logic       sdr_req,
    input  word_t      sdr_rdata,
    input  wire        sdr_rdy
);

    logic      read_d;
    logic      write_d;
    word_t     rd_data;
    cpu_addr_t word_addr;
    word_t     word_wdata;
    logic [1:0] word_sel;
    logic      writable;
    logic      start;

    // ========================================
    // Byte lane shuffle
    // ========================================

    assign word_addr  = {mem_addr[19:1], 1'b0};
    assign word_wdata = mem_addr[0] ? {mem_wdata[7:0], 8'h00} : mem_wdata;
    assign word_sel   = mem_addr[0] ? {mem_sel[0], 1'b0} : mem_sel;
    assign writable   = (mem_addr[19:16] == ram_bank);

    // Odd reads return the high byte in the low lane
    assign mem_rdata = mem_addr[0] ? {8'h00, rd_data[15:8]} : rd_data;

    // New access on a rising read or write strobe
    assign start = !mem_busy && ((mem_read && !read_d) || (mem_write && !write_d));

    // ========================================
    // Request control
    // ========================================

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            read_d   <= 1'b0;
            write_d  <= 1'b0;
            sdr_req  <= 1'b0;
            mem_busy <= 1'b0;
        end else begin
            read_d  <= mem_read;
            write_d <= mem_write;
            sdr_req <= 1'b0;

            if (start) begin
                sdr_req  <= 1'b1;
                mem_busy <= 1'b1;
            end else if (mem_busy && sdr_rdy) begin
                mem_busy <= 1'b0;
            end
        end
    end

    // Address, write data and returned word
    always_ff @(posedge CLK_32M) begin
        if (start) begin
            sdr_addr   <= sdr_cpu_base + sdr_addr_t'(word_addr);
            sdr_wdata  <= word_wdata;
            sdr_wr_sel <= (mem_write && writable) ? word_sel : 2'b00;
        end
        if (mem_busy && sdr_rdy)
            rd_data <= sdr_rdata;
    end

endmodule

`default_nettype wire

//--- design/m92_clock_enables.sv
// CPU and MCU clock enable generator
// CPU enables halt while a memory access is in flight

`timescale 1ns/1ps
`default_nettype none

module m92_clock_enables #(
    parameter int cpu_ce_div = 4,
    parameter int mcu_ce_div = 4
) (
    input  wire  CLK_32M,
    input  wire  reset_n,
    input  wire  mem_busy,
    output logic ce_cpu,
    output logic ce_cpu_4x,
    output logic ce_mcu
);

    localparam int CPU_CW = (cpu_ce_div > 1) ? $clog2(cpu_ce_div) : 1;
    localparam int MCU_CW = (mcu_ce_div > 1) ? $clog2(mcu_ce_div) : 1;

    localparam logic [CPU_CW-1:0] CPU_LAST = CPU_CW'(cpu_ce_div - 1);
    localparam logic [MCU_CW-1:0] MCU_LAST = MCU_CW'(mcu_ce_div - 1);

    logic [CPU_CW-1:0] cpu_cnt;
    logic [MCU_CW-1:0] mcu_cnt;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            ce_cpu    <= 1'b0;
            ce_cpu_4x <= 1'b0;
            ce_mcu    <= 1'b0;
            cpu_cnt   <= '0;
            mcu_cnt   <= '0;
        end else begin
            ce_cpu    <= 1'b0;
            ce_cpu_4x <= 1'b0;

            if (!mem_busy) begin   // Stall CPU during SDRAM fetch
                cpu_cnt   <= (cpu_cnt == CPU_LAST) ? '0 : cpu_cnt + 1'b1;
                ce_cpu_4x <= 1'b1;
                ce_cpu    <= (cpu_cnt == CPU_LAST);
            end

            mcu_cnt <= (mcu_cnt == MCU_LAST) ? '0 : mcu_cnt + 1'b1;
            ce_mcu  <= (mcu_cnt == MCU_LAST);
        end
    end

endmodule

`default_nettype wire

//--- design/m92_pkg.sv
// M92 glue shared definitions
// Bus widths, I/O port addresses and system flag bit positions

`default_nettype none

package m92_pkg;

    // ========================================
    // Bus types
    // ========================================

    typedef logic [19:0] cpu_addr_t;   // CPU byte address
    typedef logic [24:0] sdr_addr_t;   // SDRAM byte address
    typedef logic [15:0] word_t;
    typedef logic [4:0]  colour5_t;    // Palette colour component

    // ========================================
    // I/O map
    // ========================================

    localparam logic [7:0] IO_ADDR_SWITCHES = 8'h00;
    localparam logic [7:0] IO_ADDR_FLAGS    = 8'h02;
    localparam logic [7:0] IO_ADDR_DIPS     = 8'h04;

    // System flag register bits
    localparam int FLAG_COIN0   = 0;
    localparam int FLAG_COIN1   = 1;
    localparam int FLAG_SOFT_NL = 2;   // Stored inverted
    localparam int FLAG_CBLK    = 3;
    localparam int FLAG_BRQ     = 4;   // Sound bus request, active low

    localparam int DIP_FLIP_BIT = 8;

    // Midpoint of the unsigned sample stream
    localparam logic [7:0] SAMPLE_BIAS = 8'h80;

endpackage

`default_nettype wire
